// File: base_table.sv
`timescale 1ns/1ps

module base_table #(
	parameter logic [1:0] BASE_INIT = 2'd2
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [tage_pkg::BASE_IDX_W-1:0]   i_idx,
	output logic [1:0]                        o_ctr,
	input  tage_pkg::base_wr_t                i_wr
);
	import tage_pkg::*;

	localparam int DEPTH = 1 << BASE_IDX_W;

	logic [1:0] ctr_mem [DEPTH];

	// weakly taken after reset by default
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				ctr_mem[i] <= BASE_INIT;
			end
		end else if (i_wr.en) begin
			ctr_mem[i_wr.idx] <= i_wr.ctr;
		end
	end

	// combinational read
	assign o_ctr = ctr_mem[i_idx];

endmodule

// File: branch_history.sv
`timescale 1ns/1ps

module branch_history (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  tage_pkg::resolve_t                         i_resolve,
	output tage_pkg::fold_t [tage_pkg::NUM_TABLES-1:0] o_fold
);
	import tage_pkg::*;

	logic [HIST_LEN-1:0] hist;

	// newest outcome in bit 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hist <= '0;
		end else if (i_resolve.valid) begin
			hist <= {hist[HIST_LEN-2:0], i_resolve.taken};
		end
	end

	for (genvar g = 0; g < NUM_TABLES; g++) begin : g_fold
		localparam int LEN     = TABLE_HIST[g];
		localparam int IDX_POS = LEN % TAG_IDX_W;
		localparam int TAG_POS = LEN % TAG_W;

		logic [TAG_IDX_W-1:0] idx_fold;
		logic [TAG_W-1:0]     tag_fold;
		logic [TAG_IDX_W-1:0] idx_rot;
		logic [TAG_W-1:0]     tag_rot;

		assign idx_rot = {idx_fold[TAG_IDX_W-2:0], idx_fold[TAG_IDX_W-1]};
		assign tag_rot = {tag_fold[TAG_W-2:0], tag_fold[TAG_W-1]};

		// rotate, add the new bit, cancel the bit that falls off this table's window
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				idx_fold <= '0;
				tag_fold <= '0;
			end else if (i_resolve.valid) begin
				idx_fold <= idx_rot ^ TAG_IDX_W'(i_resolve.taken)
					^ (TAG_IDX_W'(hist[LEN-1]) << IDX_POS);
				tag_fold <= tag_rot ^ TAG_W'(i_resolve.taken)
					^ (TAG_W'(hist[LEN-1]) << TAG_POS);
			end
		end

		assign o_fold[g] = '{idx: idx_fold, tag: tag_fold};
	end

	// history and every fold only move on a resolve
	a_hist_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!i_resolve.valid |=> $stable({hist, o_fold}));

endmodule

// File: list.f
+incdir+.
tage_pkg.sv
branch_history.sv
base_table.sv
tagged_table.sv
pred_select.sv
update_ctrl.sv
tage_predictor.sv
tb_tage.sv

// File: pred_select.sv
`timescale 1ns/1ps

module pred_select (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  tage_pkg::lookup_t                            i_lookup,
	input  logic [1:0]                                   i_base_ctr,
	input  tage_pkg::tag_rd_t [tage_pkg::NUM_TABLES-1:0] i_rd,
	output tage_pkg::pred_t                              o_pred,
	output tage_pkg::branch_rec_t                        o_rec
);
	import tage_pkg::*;

	logic                  is_branch;
	prov_e                 provider;
	logic                  prov_taken;
	logic                  taken;
	branch_rec_t           rec;

	// only conditional branches are predicted, JAL falls through here
	always_comb begin
		case (i_lookup.op)
			OP_BEQ, OP_BLT, OP_BGE: is_branch = 1'b1;
			default:                is_branch = 1'b0;
		endcase
	end

	// longest hitting table wins, base otherwise
	always_comb begin
		provider   = PROV_BASE;
		prov_taken = i_base_ctr[1];
		for (int t = 0; t < NUM_TABLES; t++) begin
			if (i_rd[t].hit) begin
				provider   = prov_e'(t + 1);
				prov_taken = i_rd[t].ctr[2];
			end
		end
	end

	assign taken = is_branch && prov_taken;

	assign o_pred = '{
		is_branch: is_branch,
		taken:     taken,
		target:    taken ? i_lookup.pc + i_lookup.imm : i_lookup.pc
	};

	// snapshot of the lookup, consumed by the next resolve
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rec <= '0;
		end else if (is_branch) begin
			rec.valid      <= 1'b1;
			rec.base_idx   <= i_lookup.pc[BASE_IDX_W+1:2];
			rec.base_ctr   <= i_base_ctr;
			rec.rd         <= i_rd;
			rec.provider   <= provider;
			rec.pred_taken <= prov_taken;
		end
	end

	assign o_rec = rec;

endmodule

// File: tage_pkg.sv
package tage_pkg;

	// address and immediate width
	localparam int PC_W       = 32;
	localparam int NUM_TABLES = 4;

	// base table, 64 entries indexed by pc[7:2]
	localparam int BASE_IDX_W = 6;

	// tagged tables, 32 entries each
	localparam int TAG_IDX_W  = 5;
	localparam int TAG_W      = 6;

	// global history and per-table lengths, geometric
	localparam int HIST_LEN   = 32;
	localparam int TABLE_HIST [NUM_TABLES] = '{4, 8, 16, 32};

	typedef enum logic [5:0] {
		OP_NOP = 6'b000000,
		OP_BEQ = 6'b001011,
		OP_BLT = 6'b001100,
		OP_BGE = 6'b001101,
		OP_JAL = 6'b001110
	} op_e;

	typedef enum logic [2:0] {
		PROV_BASE = 3'd0,
		PROV_T1   = 3'd1,
		PROV_T2   = 3'd2,
		PROV_T3   = 3'd3,
		PROV_T4   = 3'd4
	} prov_e;

	typedef struct packed {
		op_e              op;
		logic [PC_W-1:0]  pc;
		logic [PC_W-1:0]  imm;
	} lookup_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} resolve_t;

	typedef struct packed {
		logic             is_branch;
		logic             taken;
		logic [PC_W-1:0]  target;
	} pred_t;

	typedef struct packed {
		logic [TAG_IDX_W-1:0] idx;
		logic [TAG_W-1:0]     tag;
	} fold_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [2:0]       ctr;
	} tag_entry_t;

	// lookup result, also kept in the branch record
	typedef struct packed {
		logic                 hit;
		logic [2:0]           ctr;
		logic [TAG_IDX_W-1:0] idx;
		logic [TAG_W-1:0]     tag;
	} tag_rd_t;

	typedef struct packed {
		logic                 en;
		logic [TAG_IDX_W-1:0] idx;
		tag_entry_t           entry;
	} tag_wr_t;

	typedef struct packed {
		logic                  en;
		logic [BASE_IDX_W-1:0] idx;
		logic [1:0]            ctr;
	} base_wr_t;

	typedef struct packed {
		logic                           valid;
		logic [BASE_IDX_W-1:0]          base_idx;
		logic [1:0]                     base_ctr;
		tag_rd_t [NUM_TABLES-1:0]       rd;
		prov_e                          provider;
		logic                           pred_taken;
	} branch_rec_t;

endpackage

// File: tage_predictor.sv
`timescale 1ns/1ps

module tage_predictor #(
	parameter logic [1:0] BASE_INIT = 2'd2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  tage_pkg::lookup_t   i_lookup,
	input  tage_pkg::resolve_t  i_resolve,
	output tage_pkg::pred_t     o_pred
);
	import tage_pkg::*;

	fold_t   [NUM_TABLES-1:0] fold;
	tag_rd_t [NUM_TABLES-1:0] tag_rd;
	tag_wr_t [NUM_TABLES-1:0] tag_wr;
	logic    [1:0]            base_ctr;
	base_wr_t                 base_wr;
	branch_rec_t              rec;

	branch_history u_history (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_resolve (i_resolve),
		.o_fold    (fold)
	);

	base_table #(
		.BASE_INIT (BASE_INIT)
	) u_base (
		.clk   (clk),
		.rst_n (rst_n),
		.i_idx (i_lookup.pc[BASE_IDX_W+1:2]),
		.o_ctr (base_ctr),
		.i_wr  (base_wr)
	);

	// T1..T4, shortest history first
	for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
		tagged_table u_table (
			.clk    (clk),
			.rst_n  (rst_n),
			.i_pc   (i_lookup.pc),
			.i_fold (fold[t]),
			.o_rd   (tag_rd[t]),
			.i_wr   (tag_wr[t])
		);
	end

	pred_select u_select (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_lookup   (i_lookup),
		.i_base_ctr (base_ctr),
		.i_rd       (tag_rd),
		.o_pred     (o_pred),
		.o_rec      (rec)
	);

	update_ctrl u_update (
		.i_rec     (rec),
		.i_resolve (i_resolve),
		.o_base_wr (base_wr),
		.o_tag_wr  (tag_wr)
	);

endmodule

// File: tagged_table.sv
`timescale 1ns/1ps

module tagged_table (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [tage_pkg::PC_W-1:0]   i_pc,
	input  tage_pkg::fold_t             i_fold,
	output tage_pkg::tag_rd_t           o_rd,
	input  tage_pkg::tag_wr_t           i_wr
);
	import tage_pkg::*;

	localparam int DEPTH = 1 << TAG_IDX_W;

	tag_entry_t           entry_mem [DEPTH];
	tag_entry_t           entry;
	logic [TAG_IDX_W-1:0] idx;
	logic [TAG_W-1:0]     tag;
	logic                 hit;

	// word-aligned pc hashed with the folded history
	assign idx = i_pc[TAG_IDX_W+1:2] ^ i_fold.idx;
	assign tag = i_pc[TAG_W+1:2] ^ i_fold.tag;

	assign entry = entry_mem[idx];

	// valid bit keeps a zero tag from matching after reset
	assign hit = entry.valid && (entry.tag == tag);

	assign o_rd = '{
		hit: hit,
		ctr: entry.ctr,
		idx: idx,
		tag: tag
	};

	// entries start invalid at the weak taken midpoint
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				entry_mem[i] <= '{valid: 1'b0, tag: '0, ctr: 3'd4};
			end
		end else if (i_wr.en) begin
			entry_mem[i_wr.idx] <= i_wr.entry;
		end
	end

endmodule

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// mirror of the predictor tables and history
logic [1:0]            m_base  [1 << BASE_IDX_W];
logic                  m_valid [NUM_TABLES][1 << TAG_IDX_W];
logic [TAG_W-1:0]      m_tag   [NUM_TABLES][1 << TAG_IDX_W];
logic [2:0]            m_ctr   [NUM_TABLES][1 << TAG_IDX_W];
logic [HIST_LEN-1:0]   m_hist;

// lookup scratch, and the branch record copied from it
logic [TAG_IDX_W-1:0]  s_idx [NUM_TABLES];
logic [TAG_W-1:0]      s_tag [NUM_TABLES];
logic [2:0]            s_ctr [NUM_TABLES];
logic [BASE_IDX_W-1:0] s_base_idx;
logic [1:0]            s_base_ctr;
int                    s_prov;
logic                  s_taken;
logic                  r_valid;
logic [TAG_IDX_W-1:0]  r_idx [NUM_TABLES];
logic [TAG_W-1:0]      r_tag [NUM_TABLES];
logic [2:0]            r_ctr [NUM_TABLES];
logic [BASE_IDX_W-1:0] r_base_idx;
logic [1:0]            r_base_ctr;
int                    r_prov;
logic                  r_taken;

task automatic reset_model();
	for (int i = 0; i < (1 << BASE_IDX_W); i++) begin
		m_base[i] = BASE_INIT;
	end
	for (int t = 0; t < NUM_TABLES; t++) begin
		for (int i = 0; i < (1 << TAG_IDX_W); i++) begin
			m_valid[t][i] = 1'b0;
			m_tag[t][i]   = '0;
			m_ctr[t][i]   = 3'd4;
		end
	end
	m_hist  = '0;
	r_valid = 1'b0;
endtask

// xor of the newest len outcomes, cut into chunks of width bits
function automatic logic [TAG_W-1:0] fold_hist(input int len, input int width);
	logic [TAG_W-1:0] f;
	f = '0;
	for (int i = 0; i < len; i++) begin
		f[i % width] ^= m_hist[i];
	end
	return f;
endfunction

function automatic logic [2:0] saturate_toward(input logic [2:0] ctr, input logic [2:0] top,
		input logic up);
	if (up && ctr < top) begin
		return ctr + 3'd1;
	end else if (!up && ctr > 3'd0) begin
		return ctr - 3'd1;
	end
	return ctr;
endfunction

task automatic look_up(input lookup_t lk, output pred_t p);
	logic [TAG_W-1:0] f_idx;
	logic [TAG_W-1:0] f_tag;
	logic [4:0]       idx;
	logic             is_br;
	logic             taken;
	s_base_idx = lk.pc[7:2];
	s_base_ctr = m_base[s_base_idx];
	s_prov     = 0;
	s_taken    = s_base_ctr[1];
	for (int t = 0; t < NUM_TABLES; t++) begin
		f_idx    = fold_hist(TABLE_HIST[t], 5);
		f_tag    = fold_hist(TABLE_HIST[t], 6);
		idx      = lk.pc[6:2] ^ f_idx[4:0];
		s_idx[t] = idx;
		s_tag[t] = lk.pc[7:2] ^ f_tag;
		s_ctr[t] = m_ctr[t][idx];
		// later tables override earlier ones
		if (m_valid[t][idx] && m_tag[t][idx] == s_tag[t]) begin
			s_prov  = t + 1;
			s_taken = s_ctr[t][2];
		end
	end
	is_br       = lk.op inside {OP_BEQ, OP_BLT, OP_BGE};
	taken       = is_br && s_taken;
	p.is_branch = is_br;
	p.taken     = taken;
	p.target    = taken ? lk.pc + lk.imm : lk.pc;
endtask

task automatic capture_record();
	r_valid    = 1'b1;
	r_idx      = s_idx;
	r_tag      = s_tag;
	r_ctr      = s_ctr;
	r_base_idx = s_base_idx;
	r_base_ctr = s_base_ctr;
	r_prov     = s_prov;
	r_taken    = s_taken;
endtask

task automatic train_on_resolve(input logic taken);
	int t;
	if (r_valid) begin
		if (r_prov == 0) begin
			m_base[r_base_idx] = 2'(saturate_toward({1'b0, r_base_ctr}, 3'd3, taken));
		end else begin
			t = r_prov - 1;
			m_valid[t][r_idx[t]] = 1'b1;
			m_tag[t][r_idx[t]]   = r_tag[t];
			m_ctr[t][r_idx[t]]   = saturate_toward(r_ctr[t], 3'd7, taken);
		end
		// a miss claims the next longer table
		if (r_taken != taken && r_prov < NUM_TABLES) begin
			t = r_prov;
			m_valid[t][r_idx[t]] = 1'b1;
			m_tag[t][r_idx[t]]   = r_tag[t];
			m_ctr[t][r_idx[t]]   = taken ? 3'd4 : 3'd3;
		end
	end
	m_hist = {m_hist[HIST_LEN-2:0], taken};
endtask

`endif

// File: tb_tage.sv
`timescale 1ns/1ps

module tb_tage;
	import tage_pkg::*;

	localparam logic [1:0] BASE_INIT = 2'd2;

	logic     clk;
	logic     rst_n;
	lookup_t  i_lookup;
	resolve_t i_resolve;
	pred_t    o_pred;

	pred_t    exp_pred;
	logic     chk_en;
	logic     want_en;
	logic     want_taken;
	resolve_t cur_rs;
	logic     cur_branch;
	logic [31:0] rng;
	int       errors;
	int       lookups;
	int       tests_failed;

	`include "tb_model.svh"

	tage_predictor #(
		.BASE_INIT (BASE_INIT)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_lookup  (i_lookup),
		.i_resolve (i_resolve),
		.o_pred    (o_pred)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	a_pred_match: assert property (@(posedge clk) disable iff (!rst_n)
		chk_en |-> (o_pred == exp_pred))
		else begin
			errors++;
			$display("[FAIL] o_pred at pc %h: expected %h got %h", $sampled(i_lookup.pc),
				$sampled(exp_pred), $sampled(o_pred));
		end

	a_taken_known: assert property (@(posedge clk) disable iff (!rst_n)
		want_en |-> (o_pred.taken == want_taken))
		else begin
			errors++;
			$display("[FAIL] o_pred.taken: expected %h got %h", $sampled(want_taken),
				$sampled(o_pred.taken));
		end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic lookup_t lookup_of(input op_e op, input logic [31:0] pc,
			input logic [31:0] imm);
		lookup_t lk;
		lk.op  = op;
		lk.pc  = pc;
		lk.imm = imm;
		return lk;
	endfunction

	// one cycle: the model takes this edge, then the new inputs go out
	task automatic drive(input lookup_t lk, input resolve_t rs);
		@(posedge clk);
		if (cur_rs.valid) begin
			train_on_resolve(cur_rs.taken);
		end
		if (cur_branch) begin
			capture_record();
		end
		want_en   = 1'b0;
		i_lookup  <= lk;
		i_resolve <= rs;
		cur_rs    = rs;
		look_up(lk, exp_pred);
		cur_branch = exp_pred.is_branch;
		chk_en     = 1'b1;
		lookups++;
	endtask

	task automatic expect_taken(input logic v);
		want_en    = 1'b1;
		want_taken = v;
	endtask

	task automatic branch_pair(input logic [31:0] pc, input logic taken);
		drive(lookup_of(OP_BEQ, pc, 32'h40), '0);
		drive(lookup_of(OP_NOP, pc, '0), '{valid: 1'b1, taken: taken});
	endtask

	task automatic report_test(input string name, input int err_before);
		drive(lookup_of(OP_NOP, '0, '0), '0);
		#1;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic wait_pred_known(output logic ok);
		ok = 1'b0;
		for (int n = 0; n < 16 && !ok; n++) begin
			@(posedge clk);
			ok = !$isunknown(o_pred);
		end
	endtask

	initial begin
		logic ok;
		int   e;
		logic [31:0] r;
		rst_n = 1'b0;
		i_lookup = '0;
		i_resolve = '0;
		chk_en = 1'b0;
		want_en = 1'b0;
		want_taken = 1'b0;
		cur_rs = '0;
		cur_branch = 1'b0;
		rng = 32'h7fbc_9c24;
		errors = 0;
		lookups = 0;
		tests_failed = 0;
		reset_model();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		wait_pred_known(ok);
		if (!ok) begin
			$display("timeout: o_pred stayed unknown after reset");
			$display("Test failed");
			$finish;
		end else begin
			e = errors;
			drive(lookup_of(OP_NOP, next_rand() & 32'hffff_fffc, next_rand()), '0);
			expect_taken(1'b0);
			drive(lookup_of(OP_JAL, next_rand() & 32'hffff_fffc, next_rand()), '0);
			expect_taken(1'b0);
			drive(lookup_of(OP_BEQ, next_rand() & 32'hffff_fffc, next_rand()), '0);
			expect_taken(1'b1);
			report_test("reset and non-branch ops", e);

			// all not-taken, history stays zero
			e = errors;
			drive(lookup_of(OP_BEQ, 32'h1040, 32'h40), '0);
			expect_taken(1'b1);
			drive(lookup_of(OP_NOP, '0, '0), '{valid: 1'b1, taken: 1'b0});
			drive(lookup_of(OP_BEQ, 32'h1040, 32'h40), '0);
			expect_taken(1'b0);
			drive(lookup_of(OP_NOP, '0, '0), '{valid: 1'b1, taken: 1'b0});
			repeat (4) branch_pair(32'h1040, 1'b0);
			report_test("base training", e);

			e = errors;
			for (int i = 0; i < 24; i++) begin
				branch_pair(32'h2084, i[0]);
			end
			report_test("chained allocation", e);

			// all-ones history holds still under taken outcomes
			e = errors;
			repeat (32) branch_pair(32'h30c8, 1'b1);
			branch_pair(32'h3010, 1'b0);
			repeat (32) branch_pair(32'h30c8, 1'b1);
			repeat (12) branch_pair(32'h3010, 1'b1);
			branch_pair(32'h3010, 1'b0);
			drive(lookup_of(OP_BEQ, 32'h3010, 32'h40), '0);
			drive(lookup_of(OP_NOP, '0, '0), '{valid: 1'b1, taken: 1'b1});
			report_test("counter saturation", e);

			// each lookup shares its cycle with the previous branch's resolve
			e = errors;
			for (int i = 0; i < 300; i++) begin
				r = next_rand();
				drive(lookup_of(r[25:24] == 2'd0 ? OP_BLT : (r[25] ? OP_BGE : OP_BEQ),
					32'h8000 + {r[7:4], 2'b00}, {r[19:8], 2'b00}),
					'{valid: (i != 0), taken: r[30]});
			end
			r = next_rand();
			drive(lookup_of(OP_NOP, '0, '0), '{valid: 1'b1, taken: r[0]});
			report_test("history folding", e);

			$display("tests: 5 run, %0d failed, %0d lookups checked, %0d errors",
				tests_failed, lookups, errors);
			if (errors == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

endmodule

// File: update_ctrl.sv
`timescale 1ns/1ps

module update_ctrl (
	input  tage_pkg::branch_rec_t                        i_rec,
	input  tage_pkg::resolve_t                           i_resolve,
	output tage_pkg::base_wr_t                           o_base_wr,
	output tage_pkg::tag_wr_t [tage_pkg::NUM_TABLES-1:0] o_tag_wr
);
	import tage_pkg::*;

	logic                  fire;
	logic                  mispred;
	logic [1:0]            base_next;
	logic [NUM_TABLES-1:0] alloc_vec;
	logic [NUM_TABLES-1:0] wr_vec;

	// one saturating step toward the outcome
	function automatic logic [2:0] sat_step(
		input logic [2:0] ctr,
		input logic [2:0] max,
		input logic       up
	);
		if (up) begin
			return (ctr == max) ? ctr : ctr + 3'd1;
		end
		return (ctr == 3'd0) ? ctr : ctr - 3'd1;
	endfunction

	assign fire    = i_resolve.valid && i_rec.valid;
	assign mispred = fire && (i_rec.pred_taken != i_resolve.taken);

	assign base_next = 2'(sat_step({1'b0, i_rec.base_ctr}, 3'd3, i_resolve.taken));

	assign o_base_wr = '{
		en:  fire && (i_rec.provider == PROV_BASE),
		idx: i_rec.base_idx,
		ctr: base_next
	};

	// train the provider, or allocate one table above it on a miss
	always_comb begin
		for (int t = 0; t < NUM_TABLES; t++) begin
			alloc_vec[t]             = mispred && (i_rec.provider == prov_e'(t));
			o_tag_wr[t].en           = 1'b0;
			o_tag_wr[t].idx          = i_rec.rd[t].idx;
			o_tag_wr[t].entry.valid  = 1'b1;
			o_tag_wr[t].entry.tag    = i_rec.rd[t].tag;
			o_tag_wr[t].entry.ctr    = sat_step(i_rec.rd[t].ctr, 3'd7, i_resolve.taken);
			if (fire && (i_rec.provider == prov_e'(t + 1))) begin
				o_tag_wr[t].en = 1'b1;
			end else if (alloc_vec[t]) begin
				o_tag_wr[t].en        = 1'b1;
				o_tag_wr[t].entry.ctr = i_resolve.taken ? 3'd4 : 3'd3;
			end
			wr_vec[t] = o_tag_wr[t].en;
		end
	end

	// a T4 provider has nowhere to allocate, so at most one table gets a new entry
	always_comb begin
		a_one_alloc: assert final ($onehot0(alloc_vec))
			else $error("update_ctrl: more than one allocation 0x%0h", alloc_vec);
	end

	// table writes come only from a resolve that has a recorded branch behind it
	always_comb begin
		a_wr_needs_rec: assert final (!(|wr_vec || o_base_wr.en) || fire)
			else $error("update_ctrl: write without valid record");
	end

endmodule
